// ==== design/dmi_pkg.sv ====
package dmi_pkg;

  ////////////////////////////////////////
  // DMI bus geometry
  ////////////////////////////////////////

  localparam int DmiAddrWidth = 7;
  localparam int DmiDataWidth = 32;

  // System bus registers reachable over DMI
  typedef enum logic [DmiAddrWidth-1:0] {
    DmiSbcs       = 7'h38,
    DmiSbAddress0 = 7'h39,
    DmiSbData0    = 7'h3C,
    DmiSbData1    = 7'h3D
  } dmi_addr_e;

  // Values reported in sbcs.sberror
  typedef enum logic [2:0] {
    SbErrNone       = 3'd0,
    SbErrBadAddr    = 3'd2,
    SbErrMisaligned = 3'd3,
    SbErrBadSize    = 3'd4
  } sb_error_e;

  ////////////////////////////////////////
  // SBCS layout
  ////////////////////////////////////////

  localparam logic [2:0] SbcsVersion  = 3'd1;
  localparam logic [6:0] SbcsAddrSize = 7'd32;

  localparam int SbcsVersionLsb    = 29;
  localparam int SbcsBusyErrBit    = 22;
  localparam int SbcsBusyBit       = 21;
  localparam int SbcsReadOnAddrBit = 20;
  localparam int SbcsAccessLsb     = 17;
  localparam int SbcsAutoIncBit    = 16;
  localparam int SbcsReadOnDataBit = 15;
  localparam int SbcsErrorLsb      = 12;
  localparam int SbcsAddrSizeLsb   = 5;

  // Access sizes the bus supports, read-only ones
  localparam int SbcsAccess64Bit = 3;
  localparam int SbcsAccess32Bit = 2;

endpackage

// ==== design/sysbus_pkg.sv ====
package sysbus_pkg;

  ////////////////////////////////////////
  // System bus widths
  ////////////////////////////////////////

  localparam int SbAddrWidth = 32;
  localparam int SbDataWidth = 64;
  localparam int SbStrbWidth = 8;

  typedef logic [SbAddrWidth-1:0] sb_addr_t;
  typedef logic [SbDataWidth-1:0] sb_data_t;
  typedef logic [SbStrbWidth-1:0] sb_strb_t;

  // Encoding follows sbcs.sbaccess
  typedef enum logic [2:0] {
    SbSize32 = 3'd2,
    SbSize64 = 3'd3
  } sb_size_e;

  ////////////////////////////////////////
  // Byte enables per access
  ////////////////////////////////////////

  localparam sb_strb_t StrbAll    = 8'hFF;
  localparam sb_strb_t StrbLow32  = 8'h0F;
  localparam sb_strb_t StrbHigh32 = 8'hF0;

endpackage

// ==== design/sb_cmd_if.sv ====
`timescale 1ns/1ps

interface sb_cmd_if;

  // Command side, held stable while req is high
  logic                 req;
  logic                 we;
  sysbus_pkg::sb_addr_t addr;
  sysbus_pkg::sb_data_t wdata;
  logic [2:0]           size;

  // Response side, valid while ack is high
  logic                 ack;
  sysbus_pkg::sb_data_t rdata;
  dmi_pkg::sb_error_e   err;

  modport requester (
    output req, we, addr, wdata, size,
    input  ack, rdata, err
  );

  modport executor (
    input  req, we, addr, wdata, size,
    output ack, rdata, err
  );

endinterface

// ==== design/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if #(
  parameter int MemWords = 256
);

  localparam int IdxWidth = $clog2(MemWords);

  logic                 req;
  logic                 we;
  logic [IdxWidth-1:0]  idx;
  sysbus_pkg::sb_data_t wdata;
  sysbus_pkg::sb_strb_t strb;

  logic                 ack;
  sysbus_pkg::sb_data_t rdata;

  modport master (
    output req, we, idx, wdata, strb,
    input  ack, rdata
  );

  modport slave (
    input  req, we, idx, wdata, strb,
    output ack, rdata
  );

endinterface

// ==== design/sba_dmi_regs.sv ====
`timescale 1ns/1ps

module sba_dmi_regs (
  input  logic                             clk_sys,
  input  logic                             arst_n_i,
  input  logic                             dmi_req_i,
  input  logic                             dmi_wr_i,
  input  logic [dmi_pkg::DmiAddrWidth-1:0] dmi_addr_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0] dmi_wdata_i,
  output logic                             dmi_ack_o,
  output logic [dmi_pkg::DmiDataWidth-1:0] dmi_rdata_o,
  sb_cmd_if.requester                      cmd
);

  typedef enum logic [1:0] {
    DmiIdle,
    DmiRespond,
    DmiWaitRelease
  } dmi_state_e;

  dmi_state_e         state_q;
  dmi_pkg::dmi_addr_e reg_addr;

  logic access;
  logic wr_en;
  logic rd_en;
  logic trig_wr;
  logic trig_rd;
  logic trigger;
  logic err_block;
  logic start;
  logic busy_hit;
  logic cmd_done;

  // SBCS control fields
  logic       busyerr_q;
  logic       readonaddr_q;
  logic [2:0] access_q;
  logic       autoinc_q;
  logic       readondata_q;
  logic [2:0] sberror_q;

  // Command tracking
  logic       busy_q;
  logic       cmd_req_q;
  logic       cmd_we_q;
  logic [2:0] cmd_size_q;

  sysbus_pkg::sb_addr_t             sbaddr0_q;
  sysbus_pkg::sb_addr_t             addr_inc;
  logic [dmi_pkg::DmiDataWidth-1:0] sbdata0_q;
  logic [dmi_pkg::DmiDataWidth-1:0] sbdata1_q;
  logic [dmi_pkg::DmiDataWidth-1:0] rdata_q;
  logic [dmi_pkg::DmiDataWidth-1:0] sbcs_rd;
  logic [dmi_pkg::DmiDataWidth-1:0] rd_mux;

  ////////////////////////////////////////
  // Register access decode
  ////////////////////////////////////////

  assign reg_addr = dmi_pkg::dmi_addr_e'(dmi_addr_i);
  assign access   = (state_q == DmiRespond);
  assign wr_en    = access && dmi_wr_i;
  assign rd_en    = access && !dmi_wr_i;

  // Three ways to kick off a bus access
  assign trig_wr = wr_en && (reg_addr == dmi_pkg::DmiSbData0);
  assign trig_rd = (wr_en && (reg_addr == dmi_pkg::DmiSbAddress0) && readonaddr_q) ||
                   (rd_en && (reg_addr == dmi_pkg::DmiSbData0) && readondata_q);
  assign trigger = trig_wr || trig_rd;

  // Sticky errors block everything until cleared
  assign err_block = (sberror_q != 3'd0) || busyerr_q;
  assign start     = trigger && !err_block && !busy_q;
  assign busy_hit  = trigger && busy_q;
  assign cmd_done  = cmd_req_q && cmd.ack;

  assign addr_inc = (cmd_size_q == sysbus_pkg::SbSize64) ? sysbus_pkg::sb_addr_t'(8) :
                                                           sysbus_pkg::sb_addr_t'(4);

  always_comb begin
    sbcs_rd = '0;
    sbcs_rd[dmi_pkg::SbcsVersionLsb +: 3]  = dmi_pkg::SbcsVersion;
    sbcs_rd[dmi_pkg::SbcsBusyErrBit]       = busyerr_q;
    sbcs_rd[dmi_pkg::SbcsBusyBit]          = busy_q;
    sbcs_rd[dmi_pkg::SbcsReadOnAddrBit]    = readonaddr_q;
    sbcs_rd[dmi_pkg::SbcsAccessLsb +: 3]   = access_q;
    sbcs_rd[dmi_pkg::SbcsAutoIncBit]       = autoinc_q;
    sbcs_rd[dmi_pkg::SbcsReadOnDataBit]    = readondata_q;
    sbcs_rd[dmi_pkg::SbcsErrorLsb +: 3]    = sberror_q;
    sbcs_rd[dmi_pkg::SbcsAddrSizeLsb +: 7] = dmi_pkg::SbcsAddrSize;
    sbcs_rd[dmi_pkg::SbcsAccess64Bit]      = 1'b1;
    sbcs_rd[dmi_pkg::SbcsAccess32Bit]      = 1'b1;
  end

  always_comb begin
    case (reg_addr)
      dmi_pkg::DmiSbcs:       rd_mux = sbcs_rd;
      dmi_pkg::DmiSbAddress0: rd_mux = sbaddr0_q;
      dmi_pkg::DmiSbData0:    rd_mux = sbdata0_q;
      dmi_pkg::DmiSbData1:    rd_mux = sbdata1_q;
      default:                rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////
  // Handshake FSM and control state
  ////////////////////////////////////////

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= DmiIdle;
      busyerr_q    <= 1'b0;
      readonaddr_q <= 1'b0;
      access_q     <= 3'd0;
      autoinc_q    <= 1'b0;
      readondata_q <= 1'b0;
      sberror_q    <= 3'd0;
      busy_q       <= 1'b0;
      cmd_req_q    <= 1'b0;
      cmd_we_q     <= 1'b0;
      cmd_size_q   <= 3'd0;
    end else begin
      case (state_q)
        DmiIdle:        if (dmi_req_i) state_q <= DmiRespond;
        DmiRespond:     state_q <= DmiWaitRelease;
        DmiWaitRelease: if (!dmi_req_i) state_q <= DmiIdle;
        default:        state_q <= DmiIdle;
      endcase

      if (wr_en && (reg_addr == dmi_pkg::DmiSbcs)) begin
        readonaddr_q <= dmi_wdata_i[dmi_pkg::SbcsReadOnAddrBit];
        access_q     <= dmi_wdata_i[dmi_pkg::SbcsAccessLsb +: 3];
        autoinc_q    <= dmi_wdata_i[dmi_pkg::SbcsAutoIncBit];
        readondata_q <= dmi_wdata_i[dmi_pkg::SbcsReadOnDataBit];
        // Write one to clear
        sberror_q    <= sberror_q & ~dmi_wdata_i[dmi_pkg::SbcsErrorLsb +: 3];
        if (dmi_wdata_i[dmi_pkg::SbcsBusyErrBit]) begin
          busyerr_q <= 1'b0;
        end
      end

      if (busy_hit) begin
        busyerr_q <= 1'b1;
      end

      if (start) begin
        cmd_req_q  <= 1'b1;
        busy_q     <= 1'b1;
        cmd_we_q   <= trig_wr;
        cmd_size_q <= access_q;
      end

      // Drop req on ack, stay busy until the executor releases ack
      if (cmd_done) begin
        cmd_req_q <= 1'b0;
        if (cmd.err != dmi_pkg::SbErrNone) begin
          sberror_q <= cmd.err;
        end
      end else if (busy_q && !cmd_req_q && !cmd.ack) begin
        busy_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Address and data registers
  ////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (rd_en) begin
      rdata_q <= rd_mux;
    end
    // Ignored while a command owns them
    if (wr_en && !busy_q) begin
      case (reg_addr)
        dmi_pkg::DmiSbAddress0: sbaddr0_q <= dmi_wdata_i;
        dmi_pkg::DmiSbData0:    sbdata0_q <= dmi_wdata_i;
        dmi_pkg::DmiSbData1:    sbdata1_q <= dmi_wdata_i;
        default: ;
      endcase
    end
    if (cmd_done && (cmd.err == dmi_pkg::SbErrNone)) begin
      if (!cmd_we_q) begin
        if (cmd_size_q == sysbus_pkg::SbSize64) begin
          sbdata1_q <= cmd.rdata[63:32];
        end
        sbdata0_q <= cmd.rdata[31:0];
      end
      if (autoinc_q) begin
        sbaddr0_q <= sbaddr0_q + addr_inc;
      end
    end
  end

  assign dmi_ack_o   = (state_q == DmiWaitRelease);
  assign dmi_rdata_o = rdata_q;

  assign cmd.req   = cmd_req_q;
  assign cmd.we    = cmd_we_q;
  assign cmd.addr  = sbaddr0_q;
  assign cmd.wdata = {sbdata1_q, sbdata0_q};
  assign cmd.size  = cmd_size_q;

endmodule

// ==== design/sba_bus_master.sv ====
`timescale 1ns/1ps

module sba_bus_master #(
  parameter int MemWords = 256
) (
  input  logic        clk_sys,
  input  logic        arst_n_i,
  sb_cmd_if.executor  cmd,
  mem_bus_if.master   mem
);

  localparam int IdxWidth = $clog2(MemWords);
  localparam sysbus_pkg::sb_addr_t MemBytes = sysbus_pkg::sb_addr_t'(MemWords * 8);

  typedef enum logic [1:0] {
    BmIdle,
    BmMemWait,
    BmDone,
    BmRelease
  } bm_state_e;

  bm_state_e            state_q;
  dmi_pkg::sb_error_e   chk_err;
  dmi_pkg::sb_error_e   err_q;
  logic                 is32;
  logic                 is64;
  logic                 mem_req_q;
  logic                 mem_we_q;
  logic                 half_q;
  logic                 size32_q;
  logic [IdxWidth-1:0]  idx_q;
  sysbus_pkg::sb_data_t wdata_q;
  sysbus_pkg::sb_data_t rdata_q;
  sysbus_pkg::sb_strb_t strb_q;

  assign is32 = (cmd.size == sysbus_pkg::SbSize32);
  assign is64 = (cmd.size == sysbus_pkg::SbSize64);

  // Size first, then alignment, then range
  always_comb begin
    if (!is32 && !is64) begin
      chk_err = dmi_pkg::SbErrBadSize;
    end else if ((is64 && (cmd.addr[2:0] != 3'b000)) || (is32 && (cmd.addr[1:0] != 2'b00))) begin
      chk_err = dmi_pkg::SbErrMisaligned;
    end else if (cmd.addr >= MemBytes) begin
      chk_err = dmi_pkg::SbErrBadAddr;
    end else begin
      chk_err = dmi_pkg::SbErrNone;
    end
  end

  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= BmIdle;
      mem_req_q <= 1'b0;
      err_q     <= dmi_pkg::SbErrNone;
    end else begin
      case (state_q)
        BmIdle: begin
          if (cmd.req) begin
            err_q <= chk_err;
            if (chk_err != dmi_pkg::SbErrNone) begin
              state_q <= BmDone;
            end else begin
              mem_req_q <= 1'b1;
              state_q   <= BmMemWait;
            end
          end
        end
        BmMemWait: begin
          if (mem.ack) begin
            mem_req_q <= 1'b0;
            state_q   <= BmDone;
          end
        end
        BmDone:    if (!cmd.req) state_q <= BmRelease;
        // Memory side must finish its handshake too
        BmRelease: if (!mem.ack) state_q <= BmIdle;
        default:   state_q <= BmIdle;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if ((state_q == BmIdle) && cmd.req) begin
      idx_q    <= cmd.addr[3 +: IdxWidth];
      mem_we_q <= cmd.we;
      half_q   <= cmd.addr[2];
      size32_q <= is32;
      // 32-bit data goes to both halves, strobes pick one
      wdata_q  <= is64 ? cmd.wdata : {2{cmd.wdata[31:0]}};
      strb_q   <= is64 ? sysbus_pkg::StrbAll :
                  (cmd.addr[2] ? sysbus_pkg::StrbHigh32 : sysbus_pkg::StrbLow32);
    end
    if ((state_q == BmMemWait) && mem.ack) begin
      if (size32_q) begin
        rdata_q <= {32'h0, half_q ? mem.rdata[63:32] : mem.rdata[31:0]};
      end else begin
        rdata_q <= mem.rdata;
      end
    end
  end

  assign cmd.ack   = (state_q == BmDone);
  assign cmd.rdata = rdata_q;
  assign cmd.err   = err_q;

  assign mem.req   = mem_req_q;
  assign mem.we    = mem_we_q;
  assign mem.idx   = idx_q;
  assign mem.wdata = wdata_q;
  assign mem.strb  = strb_q;

endmodule

// ==== design/sba_scratch_mem.sv ====
`timescale 1ns/1ps

module sba_scratch_mem #(
  parameter int MemWords = 256
) (
  input  logic      clk_sys,
  input  logic      arst_n_i,
  mem_bus_if.slave  mem
);

  sysbus_pkg::sb_data_t words [MemWords];
  sysbus_pkg::sb_data_t rdata_q;
  logic                 ack_q;
  logic                 take;

  // Act once per request, on its first cycle
  assign take = mem.req && !ack_q;

  // Ack follows req by one cycle in both directions
  always_ff @(posedge clk_sys or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= mem.req;
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (take) begin
      if (mem.we) begin
        for (int b = 0; b < sysbus_pkg::SbStrbWidth; b++) begin
          if (mem.strb[b]) begin
            words[mem.idx][8*b +: 8] <= mem.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= words[mem.idx];
    end
  end

  assign mem.ack   = ack_q;
  assign mem.rdata = rdata_q;

endmodule

// ==== design/sba_top.sv ====
`timescale 1ns/1ps

module sba_top #(
  parameter int MemWords = 256
) (
  input  logic                             clk_sys,
  input  logic                             arst_n_i,
  input  logic                             dmi_req_i,
  input  logic                             dmi_wr_i,
  input  logic [dmi_pkg::DmiAddrWidth-1:0] dmi_addr_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0] dmi_wdata_i,
  output logic                             dmi_ack_o,
  output logic [dmi_pkg::DmiDataWidth-1:0] dmi_rdata_o
);

  // Register stage to sequencer
  sb_cmd_if cmd_if ();

  // Sequencer to scratch memory
  mem_bus_if #(
    .MemWords ( MemWords )
  ) mem_if ();

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  sba_dmi_regs u_dmi_regs (
    .clk_sys     ( clk_sys     ),
    .arst_n_i    ( arst_n_i    ),
    .dmi_req_i   ( dmi_req_i   ),
    .dmi_wr_i    ( dmi_wr_i    ),
    .dmi_addr_i  ( dmi_addr_i  ),
    .dmi_wdata_i ( dmi_wdata_i ),
    .dmi_ack_o   ( dmi_ack_o   ),
    .dmi_rdata_o ( dmi_rdata_o ),
    .cmd         ( cmd_if      )
  );

  sba_bus_master #(
    .MemWords ( MemWords )
  ) u_bus_master (
    .clk_sys  ( clk_sys  ),
    .arst_n_i ( arst_n_i ),
    .cmd      ( cmd_if   ),
    .mem      ( mem_if   )
  );

  sba_scratch_mem #(
    .MemWords ( MemWords )
  ) u_scratch_mem (
    .clk_sys  ( clk_sys  ),
    .arst_n_i ( arst_n_i ),
    .mem      ( mem_if   )
  );

endmodule

// ==== bench/tb_sba_top.sv ====
`timescale 1ns/1ps

module tb_sba_top;

  localparam int MemWords    = 256;
  localparam int IdxWidth    = $clog2(MemWords);
  localparam int DmiTimeout  = 50;
  localparam int PollTimeout = 100;
  localparam int NumSteps    = 17;

  localparam int OpWrite = 0;
  localparam int OpRead  = 1;
  localparam int OpClear = 2;

  // Version 1, 32-bit addresses, 32- and 64-bit accesses supported
  localparam logic [31:0] ResetSbcs = (32'd1 << 29) | (32'd32 << 5) | 32'h8 | 32'h4;
  localparam logic [31:0] BusyAddr  = 32'h180;

  typedef struct {
    int          op;
    logic [2:0]  size;
    logic [31:0] addr;
    int          count;
    logic [2:0]  exp_err;
  } step_t;

  logic        clk_sys;
  logic        arst_n_i;
  logic        dmi_req_i;
  logic        dmi_wr_i;
  logic [6:0]  dmi_addr_i;
  logic [31:0] dmi_wdata_i;
  logic        dmi_ack_o;
  logic [31:0] dmi_rdata_o;

  logic [31:0] lcg_state;
  logic [63:0] shadow [MemWords];
  step_t       steps [NumSteps];

  sba_top #(
    .MemWords ( MemWords )
  ) uut (
    .clk_sys     ( clk_sys     ),
    .arst_n_i    ( arst_n_i    ),
    .dmi_req_i   ( dmi_req_i   ),
    .dmi_wr_i    ( dmi_wr_i    ),
    .dmi_addr_i  ( dmi_addr_i  ),
    .dmi_wdata_i ( dmi_wdata_i ),
    .dmi_ack_o   ( dmi_ack_o   ),
    .dmi_rdata_o ( dmi_rdata_o )
  );

  always #5 clk_sys = ~clk_sys;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] sbcs_word(input logic [2:0] size, input logic autoinc,
                                            input logic rd_on_addr, input logic rd_on_data,
                                            input logic [2:0] err_clr, input logic busyerr_clr);
    logic [31:0] w;
    w = '0;
    w[dmi_pkg::SbcsBusyErrBit]     = busyerr_clr;
    w[dmi_pkg::SbcsReadOnAddrBit]  = rd_on_addr;
    w[dmi_pkg::SbcsAccessLsb +: 3] = size;
    w[dmi_pkg::SbcsAutoIncBit]     = autoinc;
    w[dmi_pkg::SbcsReadOnDataBit]  = rd_on_data;
    w[dmi_pkg::SbcsErrorLsb +: 3]  = err_clr;
    return w;
  endfunction

  task automatic stop_on_failure(input string msg);
    $display("%s (time %0t ns)", msg, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Sampled on the falling edge, away from the DUT's updates
  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_sys);
      cycles++;
      if (cycles > DmiTimeout) begin
        stop_on_failure(level ? "Timed out waiting for dmi_ack_o to rise" :
                                "Timed out waiting for dmi_ack_o to fall");
      end
    end while (dmi_ack_o !== level);
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    @(posedge clk_sys);
    dmi_req_i   <= 1'b1;
    dmi_wr_i    <= 1'b1;
    dmi_addr_i  <= addr;
    dmi_wdata_i <= data;
    wait_ack(1'b1);
    @(posedge clk_sys);
    dmi_req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
    @(posedge clk_sys);
    dmi_req_i  <= 1'b1;
    dmi_wr_i   <= 1'b0;
    dmi_addr_i <= addr;
    wait_ack(1'b1);
    data = dmi_rdata_o;
    @(posedge clk_sys);
    dmi_req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic sb_wait_idle();
    logic [31:0] sbcs;
    int          polls;
    polls = 0;
    dmi_read(dmi_pkg::DmiSbcs, sbcs);
    while (sbcs[dmi_pkg::SbcsBusyBit]) begin
      polls++;
      if (polls > PollTimeout) begin
        stop_on_failure("Timed out waiting for sbbusy to clear");
      end
      dmi_read(dmi_pkg::DmiSbcs, sbcs);
    end
  endtask

  task automatic read_sberror(output logic [2:0] err);
    logic [31:0] sbcs;
    dmi_read(dmi_pkg::DmiSbcs, sbcs);
    err = sbcs[dmi_pkg::SbcsErrorLsb +: 3];
  endtask

  // 32-bit writes touch only the half chosen by address bit 2
  task automatic shadow_write(input logic [31:0] addr, input logic [2:0] size,
                              input logic [63:0] data);
    if (size == 3'd3) begin
      shadow[addr[3 +: IdxWidth]] = data;
    end else if (addr[2]) begin
      shadow[addr[3 +: IdxWidth]][63:32] = data[31:0];
    end else begin
      shadow[addr[3 +: IdxWidth]][31:0] = data[31:0];
    end
  endtask

  ////////////////////////////////////////
  // Step runners
  ////////////////////////////////////////

  task automatic run_write(input step_t s);
    logic [63:0] data;
    logic [31:0] addr;
    logic [2:0]  err;
    int          step_bytes;
    step_bytes = (s.size == 3'd3) ? 8 : 4;
    addr = s.addr;
    dmi_write(dmi_pkg::DmiSbcs, sbcs_word(s.size, s.count > 1, 1'b0, 1'b0, 3'd0, 1'b0));
    dmi_write(dmi_pkg::DmiSbAddress0, s.addr);
    for (int i = 0; i < s.count; i++) begin
      data[63:32] = lcg_next();
      data[31:0]  = lcg_next();
      dmi_write(dmi_pkg::DmiSbData1, data[63:32]);
      dmi_write(dmi_pkg::DmiSbData0, data[31:0]);
      sb_wait_idle();
      // Failed or blocked writes leave memory alone
      if (s.exp_err == 3'd0) begin
        shadow_write(addr, s.size, data);
      end
      addr = addr + step_bytes;
    end
    read_sberror(err);
    check_eq(32'(err), 32'(s.exp_err), "sberror after write");
  endtask

  task automatic run_read(input step_t s);
    logic [63:0] word;
    logic [31:0] addr;
    logic [31:0] got;
    logic [31:0] expect_lo;
    logic [2:0]  err;
    logic        stream;
    int          step_bytes;
    stream = (s.count > 1);
    step_bytes = (s.size == 3'd3) ? 8 : 4;
    addr = s.addr;
    dmi_write(dmi_pkg::DmiSbcs, sbcs_word(s.size, stream, 1'b1, stream, 3'd0, 1'b0));
    dmi_write(dmi_pkg::DmiSbAddress0, s.addr);
    sb_wait_idle();
    for (int i = 0; i < s.count; i++) begin
      word = shadow[addr[3 +: IdxWidth]];
      if (s.size == 3'd3) begin
        dmi_read(dmi_pkg::DmiSbData1, got);
        check_eq(got, word[63:32], "SBData1 read");
        expect_lo = word[31:0];
      end else begin
        expect_lo = addr[2] ? word[63:32] : word[31:0];
      end
      // With sbreadondata this also fetches the next word
      dmi_read(dmi_pkg::DmiSbData0, got);
      check_eq(got, expect_lo, "SBData0 read");
      sb_wait_idle();
      addr = addr + step_bytes;
    end
    read_sberror(err);
    check_eq(32'(err), 32'(s.exp_err), "sberror after read");
  endtask

  task automatic run_clear();
    logic [2:0] err;
    dmi_write(dmi_pkg::DmiSbcs, sbcs_word(3'd3, 1'b0, 1'b0, 1'b0, 3'd7, 1'b0));
    read_sberror(err);
    check_eq(32'(err), 32'd0, "sberror after clear");
  endtask

  task automatic check_busy_error();
    logic [31:0] hi;
    logic [31:0] lo_a;
    logic [31:0] lo_b;
    logic [31:0] lo_c;
    logic [31:0] sbcs;
    logic        busy_seen;
    hi   = lcg_next();
    lo_a = lcg_next();
    lo_b = lcg_next();
    lo_c = lcg_next();
    dmi_write(dmi_pkg::DmiSbcs, sbcs_word(3'd3, 1'b0, 1'b0, 1'b0, 3'd0, 1'b0));
    dmi_write(dmi_pkg::DmiSbAddress0, BusyAddr);
    dmi_write(dmi_pkg::DmiSbData1, hi);
    // Status read right behind the trigger falls inside the access
    dmi_write(dmi_pkg::DmiSbData0, lo_a);
    dmi_read(dmi_pkg::DmiSbcs, sbcs);
    busy_seen = sbcs[dmi_pkg::SbcsBusyBit];
    check_eq(32'(busy_seen), 32'd1, "sbbusy observed during access");
    sb_wait_idle();
    shadow_write(BusyAddr, 3'd3, {hi, lo_a});
    // Second trigger lands while the first access still runs
    dmi_write(dmi_pkg::DmiSbData0, lo_b);
    dmi_write(dmi_pkg::DmiSbData0, lo_c);
    sb_wait_idle();
    shadow_write(BusyAddr, 3'd3, {hi, lo_b});
    dmi_read(dmi_pkg::DmiSbcs, sbcs);
    check_eq(32'(sbcs[dmi_pkg::SbcsBusyErrBit]), 32'd1, "sbbusyerror after overlap");
    dmi_write(dmi_pkg::DmiSbcs, sbcs_word(3'd3, 1'b0, 1'b0, 1'b0, 3'd0, 1'b1));
    dmi_read(dmi_pkg::DmiSbcs, sbcs);
    check_eq(32'(sbcs[dmi_pkg::SbcsBusyErrBit]), 32'd0, "sbbusyerror after clear");
    run_read('{OpRead, 3'd3, BusyAddr, 1, 3'd0});
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] sbcs;
    clk_sys     = 1'b0;
    arst_n_i    = 1'b0;
    dmi_req_i   = 1'b0;
    dmi_wr_i    = 1'b0;
    dmi_addr_i  = '0;
    dmi_wdata_i = '0;
    lcg_state   = 32'hdecd;

    // Burst fill and streamed readback
    steps[0]  = '{OpWrite, 3'd3, 32'h040, 8, 3'd0};
    steps[1]  = '{OpRead,  3'd3, 32'h040, 8, 3'd0};
    // Half-word accesses
    steps[2]  = '{OpWrite, 3'd3, 32'h100, 1, 3'd0};
    steps[3]  = '{OpWrite, 3'd2, 32'h104, 1, 3'd0};
    steps[4]  = '{OpRead,  3'd3, 32'h100, 1, 3'd0};
    steps[5]  = '{OpRead,  3'd2, 32'h100, 1, 3'd0};
    steps[6]  = '{OpRead,  3'd2, 32'h104, 1, 3'd0};
    steps[7]  = '{OpWrite, 3'd3, 32'h108, 1, 3'd0};
    // Error cases, the blocked write must not reach memory
    steps[8]  = '{OpWrite, 3'd3, 32'h800, 1, 3'd2};
    steps[9]  = '{OpClear, 3'd3, 32'h000, 0, 3'd0};
    steps[10] = '{OpWrite, 3'd3, 32'h004, 1, 3'd3};
    steps[11] = '{OpWrite, 3'd3, 32'h108, 1, 3'd3};
    steps[12] = '{OpClear, 3'd3, 32'h000, 0, 3'd0};
    steps[13] = '{OpRead,  3'd3, 32'h108, 1, 3'd0};
    steps[14] = '{OpWrite, 3'd1, 32'h000, 1, 3'd4};
    steps[15] = '{OpClear, 3'd3, 32'h000, 0, 3'd0};
    steps[16] = '{OpRead,  3'd3, 32'h040, 2, 3'd0};

    repeat (10) @(posedge clk_sys);
    arst_n_i <= 1'b1;
    @(negedge clk_sys);
    check_eq(32'(dmi_ack_o), 32'd0, "dmi_ack_o after reset");
    dmi_read(dmi_pkg::DmiSbcs, sbcs);
    check_eq(sbcs, ResetSbcs, "SBCS after reset");

    for (int i = 0; i < NumSteps; i++) begin
      case (steps[i].op)
        OpWrite: run_write(steps[i]);
        OpRead:  run_read(steps[i]);
        default: run_clear();
      endcase
    end
    check_busy_error();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/dmi_pkg.sv
design/sysbus_pkg.sv
design/sb_cmd_if.sv
design/mem_bus_if.sv
design/sba_dmi_regs.sv
design/sba_bus_master.sv
design/sba_scratch_mem.sv
design/sba_top.sv
bench/tb_sba_top.sv

// ==== Makefile ====
# Verilator flow for the system bus access block

VERILATOR ?= verilator
TOP       ?= tb_sba_top
RTL_TOP   ?= sba_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
